// ==== build.f ====
+incdir+include
source/afifo_pkg.sv
source/afifo_ptr_sync.sv
source/afifo_wr_ctrl.sv
source/afifo_rd_ctrl.sv
source/afifo_ecc_enc.sv
source/afifo_ram.sv
source/afifo_ecc_dec.sv
source/afifo_top.sv
sim/afifo_checker.sv
sim/tb_afifo_top.sv

// ==== Bender.yml ====
package:
  name: afifo

export_include_dirs:
  - include

sources:
  # design, in compile order
  - files:
      - source/afifo_pkg.sv
      - source/afifo_ptr_sync.sv
      - source/afifo_wr_ctrl.sv
      - source/afifo_rd_ctrl.sv
      - source/afifo_ecc_enc.sv
      - source/afifo_ram.sv
      - source/afifo_ecc_dec.sv
      - source/afifo_top.sv

  # testbench and bound checker
  - target: test
    files:
      - sim/afifo_checker.sv
      - sim/tb_afifo_top.sv

// ==== sim/tb_afifo_top.sv ====
`include "afifo_defines.svh"

module tb_afifo_top;

    timeunit 1ns;
    timeprecision 100ps;

    import afifo_pkg::*;

    // ------------------------------------------------------------------
    // run length, in clock cycles
    // ------------------------------------------------------------------
    localparam int CLK_NS     = 4;
    localparam int RST_CYC    = 10;
    localparam int FILL_CYC   = 2 * `AFIFO_DEPTH;
    localparam int OVR_CYC    = 4;
    localparam int DRAIN_CYC  = 2 * `AFIFO_DEPTH;
    localparam int UDR_CYC    = 4;
    localparam int RAND_CYC   = 400;
    localparam int BYP_CYC    = 160;
    localparam int TAIL_CYC   = 64;                 // final drain of random traffic
    localparam int TOTAL_CYC  = RST_CYC + FILL_CYC + OVR_CYC + DRAIN_CYC + UDR_CYC
                                + RAND_CYC + BYP_CYC + TAIL_CYC;
    localparam int TIMEOUT_NS = 2 * TOTAL_CYC * CLK_NS + 400;

    logic   wr_clk;
    logic   wr_rst_n;
    logic   wr_en;
    data_t  wr_data;
    logic [1:0] err_inject;
    ptr_t   prog_full_assert_cfg;
    ptr_t   prog_full_negate_cfg;
    logic   full;
    logic   prog_full;
    logic   ovf_int;
    logic   rd_clk;
    logic   rd_rst_n;
    logic   rd_en;
    logic   ecc_bypass;
    logic   empty;
    logic   prog_empty;
    ptr_t   data_count;
    logic   udf_int;
    data_t  rd_data;
    logic   rd_data_val;
    logic   single_err;
    logic   double_err;
    integer seed;
    int     tb_errs = 0;                            // failures outside the checker
    int     total;

    afifo_top uut (
        .wr_clk               (wr_clk),
        .wr_rst_n             (wr_rst_n),
        .wr_en                (wr_en),
        .wr_data              (wr_data),
        .err_inject           (err_inject),
        .prog_full_assert_cfg (prog_full_assert_cfg),
        .prog_full_negate_cfg (prog_full_negate_cfg),
        .full                 (full),
        .prog_full            (prog_full),
        .ovf_int              (ovf_int),
        .rd_clk               (rd_clk),
        .rd_rst_n             (rd_rst_n),
        .rd_en                (rd_en),
        .ecc_bypass           (ecc_bypass),
        .empty                (empty),
        .prog_empty           (prog_empty),
        .data_count           (data_count),
        .udf_int              (udf_int),
        .rd_data              (rd_data),
        .rd_data_val          (rd_data_val),
        .single_err           (single_err),
        .double_err           (double_err)
    );

    initial begin
        wr_clk = 1'b0;
        forever #(CLK_NS / 2) wr_clk = ~wr_clk;
    end

    initial begin
        rd_clk = 1'b0;
        #1;                                         // read clock trails by 1 ns
        forever #(CLK_NS / 2) rd_clk = ~rd_clk;
    end

    // ------------------------------------------------------------------
    // stimulus tasks, writes on negedge wr_clk, reads on negedge rd_clk
    // ------------------------------------------------------------------
    task automatic write_until_full();
        @(negedge wr_clk);
        while (!full) begin
            wr_en   = 1'b1;
            wr_data = $random(seed);
            @(negedge wr_clk);
        end
    endtask

    task automatic write_while_full(input int n);
        repeat (n) begin
            @(negedge wr_clk);
            wr_en   = 1'b1;
            wr_data = $random(seed);
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
    endtask

    // sparse reads avoid holding rd_en on a single word in flight
    task automatic read_until_empty(input bit sparse);
        @(negedge rd_clk);
        while (!(empty && data_count == '0)) begin
            rd_en = sparse ? 1'($random(seed)) : 1'b1;
            @(negedge rd_clk);
        end
        rd_en = 1'b0;
    endtask

    task automatic read_while_empty(input int n);
        repeat (n) begin
            @(negedge rd_clk);
            rd_en = 1'b1;
        end
        @(negedge rd_clk);
        rd_en = 1'b0;
    endtask

    task automatic random_traffic(input int n, input bit byp);
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    @(negedge wr_clk);
                    // heavy writes first, light writes later, level sweeps full to empty
                    wr_en      = (i < n / 2) ? |2'($random(seed)) : &2'($random(seed));
                    wr_data    = $random(seed);
                    err_inject = 2'($random(seed));
                end
                @(negedge wr_clk);
                wr_en      = 1'b0;
                err_inject = 2'd0;
            end
            begin
                @(negedge rd_clk);
                ecc_bypass = byp;
                for (int i = 0; i < n; i++) begin
                    @(negedge rd_clk);
                    rd_en = 1'($random(seed));
                end
                @(negedge rd_clk);
                rd_en = 1'b0;
            end
        join
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        seed                 = 23;
        wr_rst_n             = 1'b0;
        rd_rst_n             = 1'b0;
        wr_en                = 1'b0;
        wr_data              = '0;
        err_inject           = 2'd0;
        prog_full_assert_cfg = ptr_t'(12);
        prog_full_negate_cfg = ptr_t'(8);
        rd_en                = 1'b0;
        ecc_bypass           = 1'b0;
        repeat (RST_CYC) @(negedge wr_clk);
        wr_rst_n = 1'b1;
        @(negedge rd_clk);
        rd_rst_n = 1'b1;

        write_until_full();
        write_while_full(OVR_CYC);
        read_until_empty(1'b0);
        read_while_empty(UDR_CYC);
        random_traffic(RAND_CYC, 1'b0);
        random_traffic(BYP_CYC, 1'b1);

        // let the last writes cross, then empty the FIFO with ECC on again
        @(negedge rd_clk);
        ecc_bypass = 1'b0;
        repeat (8) @(negedge wr_clk);
        read_until_empty(1'b1);
        repeat (2 * `AFIFO_RAM_PIPE_STAGE) @(negedge rd_clk);

        if (uut.u_checker.pending != 0) begin
            tb_errs++;
            $display("reference queue still holds %0d words after the final drain",
                     uut.u_checker.pending);
        end

        total = uut.u_checker.err_cnt + tb_errs;
        $display("errors: %0d total, %0d from assertions, %0d from the testbench",
                 total, uut.u_checker.err_cnt, tb_errs);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog, twice the nominal run plus margin
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("errors: %0d from assertions, %0d from the testbench",
                 uut.u_checker.err_cnt, tb_errs);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== sim/afifo_checker.sv ====
`include "afifo_defines.svh"

module afifo_checker (
    input logic             wr_clk,
    input logic             wr_rst_n,
    input logic             wr_en,
    input afifo_pkg::data_t wr_data,
    input logic [1:0]       err_inject,
    input logic             full,
    input logic             prog_full,
    input logic             ovf_int,
    input logic             rd_clk,
    input logic             rd_rst_n,
    input logic             rd_en,
    input logic             ecc_bypass,
    input logic             empty,
    input logic             prog_empty,
    input afifo_pkg::ptr_t  data_count,
    input logic             udf_int,
    input afifo_pkg::data_t rd_data,
    input logic             rd_data_val,
    input logic             single_err,
    input logic             double_err
);

    timeunit 1ns;
    timeprecision 100ps;

    import afifo_pkg::*;

    localparam int ENTRY_W = $bits(data_t) + 2;     // {err_inject, wr_data}

    int                 err_cnt = 0;                // failed assertions so far
    logic [ENTRY_W-1:0] ref_mem [256];              // ring of accepted writes
    logic [7:0]         wr_idx;
    logic [7:0]         rd_idx;
    logic [7:0]         pending;                    // words written, not yet seen
    data_t              exp_data;
    logic [1:0]         exp_inj;
    logic               exp_avail;
    data_t              exp_raw;                    // written word with its flips
    data_t              exp_word;                   // what rd_data must show
    logic               exp_single;
    logic               exp_double;

    // ------------------------------------------------------------------
    // reference queue
    // ------------------------------------------------------------------
    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_idx <= '0;
        end else if (wr_en && !full) begin          // write while not full
            ref_mem[wr_idx] <= {err_inject, wr_data};
            wr_idx          <= wr_idx + 1'b1;
        end
    end

    // one word leaves per valid read beat
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) rd_idx <= '0;
        else if (rd_data_val) rd_idx <= rd_idx + 1'b1;
    end

    assign {exp_inj, exp_data} = ref_mem[rd_idx];
    assign exp_avail           = (wr_idx != rd_idx);
    assign pending             = wr_idx - rd_idx;

    // expected output for the oldest word
    always_comb begin
        case (exp_inj)
            2'd1, 2'd3: exp_raw = exp_data ^ data_t'(1);    // check bit flip not visible
            2'd2:       exp_raw = exp_data ^ data_t'(3);
            default:    exp_raw = exp_data;
        endcase
        // doubles stay uncorrected, bypass shows raw bits
        exp_word   = (ecc_bypass || exp_inj[1]) ? exp_raw : exp_data;
        exp_single = !ecc_bypass && (exp_inj == 2'd1);
        exp_double = !ecc_bypass && exp_inj[1];
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------
    a_read_word: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        rd_data_val |-> exp_avail && (rd_data == exp_word)
                        && (single_err == exp_single) && (double_err == exp_double))
    else begin
        err_cnt++;
        $error("t=%0t read word or ECC flags differ from the oldest write", $time);
    end

    a_latency: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        rd_data_val == $past(rd_en && !empty, `AFIFO_RAM_PIPE_STAGE))
    else begin
        err_cnt++;
        $error("t=%0t rd_data_val out of step with accepted reads", $time);
    end

    a_underflow: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        udf_int == $past(rd_en && empty))
    else begin
        err_cnt++;
        $error("t=%0t udf_int wrong after a read while empty", $time);
    end

    // never more words reported than written and not yet delivered
    a_data_count: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        8'(data_count) <= pending)
    else begin
        err_cnt++;
        $error("t=%0t data_count above the words still queued", $time);
    end

    a_prog_empty_set: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        data_count <= `AFIFO_PROG_EMPTY_ASSERT |=> prog_empty)
    else begin
        err_cnt++;
        $error("t=%0t prog_empty low at a low data_count", $time);
    end

    a_prog_empty_clr: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
        data_count > `AFIFO_PROG_EMPTY_NEGATE |=> !prog_empty)
    else begin
        err_cnt++;
        $error("t=%0t prog_empty high at a high data_count", $time);
    end

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    a_overflow: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
        ovf_int == $past(wr_en && full))
    else begin
        err_cnt++;
        $error("t=%0t ovf_int wrong after a write while full", $time);
    end

    a_full_prog: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
        full |-> prog_full)
    else begin
        err_cnt++;
        $error("t=%0t full without prog_full", $time);
    end

    // flag values right after reset release
    a_wr_reset: assert property (@(posedge wr_clk)
        $rose(wr_rst_n) |-> !full && !prog_full && !ovf_int)
    else begin
        err_cnt++;
        $error("t=%0t write flags wrong after reset", $time);
    end

    a_rd_reset: assert property (@(posedge rd_clk)
        $rose(rd_rst_n) |-> empty && prog_empty && !rd_data_val && !udf_int)
    else begin
        err_cnt++;
        $error("t=%0t read flags wrong after reset", $time);
    end

endmodule

bind afifo_top afifo_checker u_checker (.*);

// ==== source/afifo_top.sv ====
module afifo_top (
    // write side
    input  logic             wr_clk,
    input  logic             wr_rst_n,
    input  logic             wr_en,
    input  afifo_pkg::data_t wr_data,
    input  logic [1:0]       err_inject,
    input  afifo_pkg::ptr_t  prog_full_assert_cfg,
    input  afifo_pkg::ptr_t  prog_full_negate_cfg,
    output logic             full,
    output logic             prog_full,
    output logic             ovf_int,
    // read side
    input  logic             rd_clk,
    input  logic             rd_rst_n,
    input  logic             rd_en,
    input  logic             ecc_bypass,
    output logic             empty,
    output logic             prog_empty,
    output afifo_pkg::ptr_t  data_count,
    output logic             udf_int,
    output afifo_pkg::data_t rd_data,
    output logic             rd_data_val,
    output logic             single_err,
    output logic             double_err
);

    logic             wen;
    logic             ren;
    afifo_pkg::addr_t wr_addr;
    afifo_pkg::addr_t rd_addr;
    afifo_pkg::ptr_t  wr_ptr_gray;
    afifo_pkg::ptr_t  rd_ptr_gray;
    afifo_pkg::ptr_t  wr_ptr_sync;          // in rd_clk
    afifo_pkg::ptr_t  rd_ptr_sync;          // in wr_clk
    afifo_pkg::code_t wr_code;
    afifo_pkg::code_t rd_code;

    // -----------------------------------------------------------------
    // write domain
    // -----------------------------------------------------------------
    afifo_wr_ctrl u_wr_ctrl (
        .wr_clk               (wr_clk),
        .wr_rst_n             (wr_rst_n),
        .wr_en                (wr_en),
        .rd_ptr_sync          (rd_ptr_sync),
        .prog_full_assert_cfg (prog_full_assert_cfg),
        .prog_full_negate_cfg (prog_full_negate_cfg),
        .wen                  (wen),
        .wr_addr              (wr_addr),
        .wr_ptr_gray          (wr_ptr_gray),
        .full                 (full),
        .prog_full            (prog_full),
        .ovf_int              (ovf_int)
    );

    afifo_ptr_sync u_rd_ptr_sync (              // read pointer into wr_clk
        .clk      (wr_clk),
        .rst_n    (wr_rst_n),
        .ptr_gray (rd_ptr_gray),
        .ptr_bin  (rd_ptr_sync)
    );

    afifo_ecc_enc u_ecc_enc (
        .wr_data    (wr_data),
        .err_inject (err_inject),
        .wr_code    (wr_code)
    );

    // storage sits between the domains
    afifo_ram u_ram (
        .wr_clk      (wr_clk),
        .wen         (wen),
        .wr_addr     (wr_addr),
        .wr_code     (wr_code),
        .rd_clk      (rd_clk),
        .rd_rst_n    (rd_rst_n),
        .ren         (ren),
        .rd_addr     (rd_addr),
        .rd_code     (rd_code),
        .rd_data_val (rd_data_val)
    );

    // -----------------------------------------------------------------
    // read domain
    // -----------------------------------------------------------------
    afifo_rd_ctrl u_rd_ctrl (
        .rd_clk      (rd_clk),
        .rd_rst_n    (rd_rst_n),
        .rd_en       (rd_en),
        .wr_ptr_sync (wr_ptr_sync),
        .ren         (ren),
        .rd_addr     (rd_addr),
        .rd_ptr_gray (rd_ptr_gray),
        .empty       (empty),
        .prog_empty  (prog_empty),
        .data_count  (data_count),
        .udf_int     (udf_int)
    );

    afifo_ptr_sync u_wr_ptr_sync (              // write pointer into rd_clk
        .clk      (rd_clk),
        .rst_n    (rd_rst_n),
        .ptr_gray (wr_ptr_gray),
        .ptr_bin  (wr_ptr_sync)
    );

    afifo_ecc_dec u_ecc_dec (
        .rd_code     (rd_code),
        .rd_data_val (rd_data_val),
        .ecc_bypass  (ecc_bypass),
        .rd_data     (rd_data),
        .single_err  (single_err),
        .double_err  (double_err)
    );

endmodule

// ==== source/afifo_ecc_dec.sv ====
`include "afifo_defines.svh"

module afifo_ecc_dec (
    input  afifo_pkg::code_t rd_code,
    input  logic             rd_data_val,
    input  logic             ecc_bypass,        // pass raw data, no flags
    output afifo_pkg::data_t rd_data,
    output logic             single_err,        // corrected
    output logic             double_err         // detected only
);

    import afifo_pkg::*;

    data_t                       raw;
    data_t                       fixed;
    logic [`AFIFO_ECC_WIDTH-2:0] syndrome;      // position of a single flip
    logic                        parity_odd;    // odd count of flipped bits
    logic                        hit;           // nonzero syndrome
    logic                        flag_en;

    assign raw        = rd_code[`AFIFO_ECC_WIDTH +: `AFIFO_DATA_WIDTH];
    assign syndrome   = ham_check(raw) ^ rd_code[`AFIFO_ECC_WIDTH-2:0];
    assign parity_odd = ^rd_code;               // covers data, ham and parity
    assign hit        = (syndrome != '0);

    // -----------------------------------------------------------------
    // correction
    // -----------------------------------------------------------------
    // a syndrome on a power of two points at a check bit
    // and matches no data position, data stays as read
    always_comb begin
        fixed = raw;
        for (int i = 0; i < `AFIFO_DATA_WIDTH; i++) begin
            if (parity_odd && (ham_pos(i) == syndrome)) fixed[i] = ~raw[i];
        end
    end

    assign rd_data = ecc_bypass ? raw : fixed;

    // flags only mean something on a valid word
    assign flag_en    = rd_data_val && !ecc_bypass;
    assign single_err = flag_en && hit && parity_odd;
    assign double_err = flag_en && hit && !parity_odd;  // even flips, can't fix

endmodule

// ==== source/afifo_ram.sv ====
`include "afifo_defines.svh"

module afifo_ram (
    input  logic             wr_clk,
    input  logic             wen,
    input  afifo_pkg::addr_t wr_addr,
    input  afifo_pkg::code_t wr_code,
    input  logic             rd_clk,
    input  logic             rd_rst_n,
    input  logic             ren,
    input  afifo_pkg::addr_t rd_addr,
    output afifo_pkg::code_t rd_code,           // delayed RAM_PIPE_STAGE cycles
    output logic             rd_data_val
);

    import afifo_pkg::*;

    localparam int STAGES = `AFIFO_RAM_PIPE_STAGE;

    code_t             mem [`AFIFO_DEPTH];
    code_t             code_pipe [STAGES];      // stage 0 is the array read
    logic [STAGES-1:0] val_pipe;

    // write port
    always_ff @(posedge wr_clk) begin
        if (wen) mem[wr_addr] <= wr_code;
    end

    // -----------------------------------------------------------------
    // read pipeline, payload only moves
    // -----------------------------------------------------------------
    always_ff @(posedge rd_clk) begin
        if (ren) code_pipe[0] <= mem[rd_addr];
        for (int i = 1; i < STAGES; i++) begin
            code_pipe[i] <= code_pipe[i-1];
        end
    end

    // valid follows the codeword stage by stage
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) val_pipe <= '0;
        else           val_pipe <= (val_pipe << 1) | STAGES'(ren);
    end

    assign rd_code     = code_pipe[STAGES-1];
    assign rd_data_val = val_pipe[STAGES-1];

endmodule

// ==== source/afifo_ecc_enc.sv ====
`include "afifo_defines.svh"

module afifo_ecc_enc (
    input  afifo_pkg::data_t wr_data,
    input  logic [1:0]       err_inject,        // 0 none, 1 single, 2 and 3 double
    output afifo_pkg::code_t wr_code
);

    import afifo_pkg::*;

    logic [`AFIFO_ECC_WIDTH-2:0] ham;           // hamming check bits
    logic                        parity;        // overall, over data and ham
    code_t                       clean;
    code_t                       flip;          // bits to corrupt

    assign ham    = ham_check(wr_data);
    assign parity = ^{wr_data, ham};
    assign clean  = {wr_data, parity, ham};

    // data bit 0 sits right above the check field
    always_comb begin
        flip = '0;
        case (err_inject)
            2'd1: flip[`AFIFO_ECC_WIDTH] = 1'b1;
            2'd2: flip[`AFIFO_ECC_WIDTH +: 2] = 2'b11;
            2'd3: begin
                flip[`AFIFO_ECC_WIDTH] = 1'b1;
                flip[0]                = 1'b1;  // check bit 0
            end
            default: flip = '0;
        endcase
    end

    assign wr_code = clean ^ flip;

endmodule

// ==== source/afifo_rd_ctrl.sv ====
`include "afifo_defines.svh"

module afifo_rd_ctrl (
    input  logic             rd_clk,
    input  logic             rd_rst_n,
    input  logic             rd_en,
    input  afifo_pkg::ptr_t  wr_ptr_sync,           // write pointer seen from rd_clk
    output logic             ren,                   // accepted read
    output afifo_pkg::addr_t rd_addr,
    output afifo_pkg::ptr_t  rd_ptr_gray,           // toward the wr_clk synchronizer
    output logic             empty,
    output logic             prog_empty,
    output afifo_pkg::ptr_t  data_count,
    output logic             udf_int
);

    import afifo_pkg::*;

    ptr_t rd_ptr;                                   // binary, msb is the wrap bit

    assign ren        = rd_en && !empty;            // drop reads while empty
    assign rd_addr    = addr_t'(rd_ptr);
    assign data_count = wr_ptr_sync - rd_ptr;       // words available

    // -----------------------------------------------------------------
    // pointer and its gray image
    // -----------------------------------------------------------------
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
        end else begin
            if (ren) rd_ptr <= rd_ptr + 1'b1;
            rd_ptr_gray <= rd_ptr ^ (rd_ptr >> 1);
        end
    end

    // -----------------------------------------------------------------
    // flags
    // -----------------------------------------------------------------
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            empty      <= 1'b1;                     // nothing stored yet
            prog_empty <= 1'b1;
            udf_int    <= 1'b0;
        end else begin
            // lookahead on the last word
            empty   <= (data_count == '0) || ((data_count == 1) && rd_en);
            udf_int <= rd_en && empty;
            // fixed hysteresis, holds in between
            if (data_count <= `AFIFO_PROG_EMPTY_ASSERT) begin
                prog_empty <= 1'b1;
            end else if (data_count > `AFIFO_PROG_EMPTY_NEGATE) begin
                prog_empty <= 1'b0;
            end
        end
    end

endmodule

// ==== source/afifo_wr_ctrl.sv ====
`include "afifo_defines.svh"

module afifo_wr_ctrl (
    input  logic             wr_clk,
    input  logic             wr_rst_n,
    input  logic             wr_en,
    input  afifo_pkg::ptr_t  rd_ptr_sync,           // read pointer seen from wr_clk
    input  afifo_pkg::ptr_t  prog_full_assert_cfg,
    input  afifo_pkg::ptr_t  prog_full_negate_cfg,
    output logic             wen,                   // accepted write
    output afifo_pkg::addr_t wr_addr,
    output afifo_pkg::ptr_t  wr_ptr_gray,           // toward the rd_clk synchronizer
    output logic             full,
    output logic             prog_full,
    output logic             ovf_int
);

    import afifo_pkg::*;

    ptr_t wr_ptr;                                   // binary, msb is the wrap bit
    ptr_t wr_gap;                                   // free entries
    ptr_t wr_cnt;                                   // fill level as seen here

    assign wen     = wr_en && !full;                // drop writes while full
    assign wr_addr = addr_t'(wr_ptr);

    // depth minus fill, wraps to zero when full
    assign wr_gap = ptr_t'(rd_ptr_sync - wr_ptr + `AFIFO_DEPTH);
    assign wr_cnt = wr_ptr - rd_ptr_sync;

    // -----------------------------------------------------------------
    // pointer and its gray image
    // -----------------------------------------------------------------
    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
        end else begin
            if (wen) wr_ptr <= wr_ptr + 1'b1;
            wr_ptr_gray <= wr_ptr ^ (wr_ptr >> 1);  // one cycle behind wr_ptr
        end
    end

    // -----------------------------------------------------------------
    // flags
    // -----------------------------------------------------------------
    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            full      <= 1'b0;
            prog_full <= 1'b0;
            ovf_int   <= 1'b0;
        end else begin
            // lookahead, last slot being taken this cycle
            full    <= (wr_gap == '0) || ((wr_gap == 1) && wr_en);
            ovf_int <= wr_en && full;               // one-cycle pulse
            if (wr_cnt >= prog_full_assert_cfg) begin
                prog_full <= 1'b1;
            end else if (wr_cnt < prog_full_negate_cfg) begin
                prog_full <= 1'b0;
            end
        end
    end

endmodule

// ==== source/afifo_ptr_sync.sv ====
module afifo_ptr_sync (
    input  logic            clk,            // destination domain clock
    input  logic            rst_n,
    input  afifo_pkg::ptr_t ptr_gray,       // registered gray pointer, other domain
    output afifo_pkg::ptr_t ptr_bin         // synchronized, back in binary
);

    import afifo_pkg::*;

    ptr_t meta_q;                           // first stage, may go metastable
    ptr_t sync_q;                           // second stage, safe to use

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= ptr_gray;
            sync_q <= meta_q;
        end
    end

    // gray to binary
    // bit i is the xor of all gray bits from i upward
    always_comb begin
        for (int i = 0; i < $bits(ptr_t); i++) begin
            ptr_bin[i] = ^(sync_q >> i);
        end
    end

endmodule

// ==== source/afifo_pkg.sv ====
`include "afifo_defines.svh"

package afifo_pkg;

    // pointers carry one wrap bit above the address
    typedef logic [`AFIFO_ADDR_WIDTH:0]   ptr_t;
    typedef logic [`AFIFO_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AFIFO_DATA_WIDTH-1:0] data_t;

    // stored word, data in the upper bits, {parity, hamming} below
    typedef logic [`AFIFO_DATA_WIDTH+`AFIFO_ECC_WIDTH-1:0] code_t;

    // hamming position of data bit idx, skipping the powers of two
    function automatic logic [`AFIFO_ECC_WIDTH-2:0] ham_pos(input int idx);
        int cnt;
        logic [`AFIFO_ECC_WIDTH-2:0] pos;
        cnt = 0;
        pos = '0;
        for (int p = 3; p < 64; p++) begin
            if ((p & (p - 1)) != 0) begin        // not a check position
                if (cnt == idx) pos = p[`AFIFO_ECC_WIDTH-2:0];
                cnt++;
            end
        end
        return pos;
    endfunction

    // hamming check bits = xor of positions of all set data bits
    function automatic logic [`AFIFO_ECC_WIDTH-2:0] ham_check(input data_t d);
        logic [`AFIFO_ECC_WIDTH-2:0] chk;
        chk = '0;
        for (int i = 0; i < `AFIFO_DATA_WIDTH; i++) begin
            if (d[i]) chk ^= ham_pos(i);
        end
        return chk;
    endfunction

endpackage

// ==== include/afifo_defines.svh ====
`ifndef AFIFO_DEFINES_SVH
`define AFIFO_DEFINES_SVH

// ---------------------------------------------------------------------
// geometry
// ---------------------------------------------------------------------
`define AFIFO_ADDR_WIDTH        4                           // 16 entries
`define AFIFO_DEPTH             (1 << `AFIFO_ADDR_WIDTH)
`define AFIFO_DATA_WIDTH        32                          // payload bits

// six hamming bits plus overall parity on top
`define AFIFO_ECC_WIDTH         7

// read latency in rd_clk cycles after an accepted read
`define AFIFO_RAM_PIPE_STAGE    2

// ---------------------------------------------------------------------
// prog_empty hysteresis, compared against data_count
// ---------------------------------------------------------------------
`define AFIFO_PROG_EMPTY_ASSERT 4                           // set at or below
`define AFIFO_PROG_EMPTY_NEGATE 6                           // clear above

`endif
